// File: hw/pmod_pkg.sv
// Shared types and constants for the eurorack codec interface.
// Holds the sample and frame types, the per-channel calibration tables
// and the UART framer state encoding.
`default_nettype none

package pmod_pkg;

    localparam int n_channels = 4;
    localparam int sample_w = 16;

    localparam int clk_freq = 12_000_000;
    localparam int baud_rate = 1_000_000;
    localparam int clks_per_bit = clk_freq / baud_rate;

    // 12 MHz / 128 gives a 93.75 kHz sample rate
    localparam int frame_clks = 128;

    typedef logic signed [sample_w-1:0] sample_t;

    // Channel 0 sits in the top bits, matching the order on the serial line
    typedef struct packed {
        sample_t ch0;
        sample_t ch1;
        sample_t ch2;
        sample_t ch3;
    } sample_frame_t;

    // Gain is Q4.12, so 4096 is unity
    typedef struct packed {
        logic signed [15:0] offset;
        logic signed [15:0] gain;
    } cal_coef_t;

    localparam cal_coef_t adc_cal_tab [n_channels] = '{
        '{offset: -16'sd120, gain: 16'sd4300},
        '{offset: 16'sd85, gain: 16'sd4150},
        '{offset: -16'sd40, gain: 16'sd4420},
        '{offset: 16'sd210, gain: 16'sd4010}
    };

    localparam cal_coef_t dac_cal_tab [n_channels] = '{
        '{offset: 16'sd60, gain: 16'sd3980},
        '{offset: -16'sd75, gain: 16'sd4120},
        '{offset: 16'sd30, gain: 16'sd4060},
        '{offset: -16'sd140, gain: 16'sd4210}
    };

    // Output calibration level, roughly 5 V at the jack
    localparam int force_level = 20000;

    typedef enum logic [2:0] {
        xmit_c,
        xmit_h,
        xmit_id,
        xmit_msb,
        xmit_lsb
    } xmit_state_t;

endpackage

`default_nettype wire

// File: hw/codec_serial.sv
// Serial port to the audio codec in TDM mode, 4 slots of 16 bits.
// Drives the bit and frame clocks, collects one ADC frame per sample
// period and shifts the DAC frame out during the following period.
`timescale 1ns/1ps
`default_nettype none

module codec_serial (
    input  wire logic                    clk_12mhz,
    input  wire logic                    rst_n,
    input  wire logic                    sdout,
    input  wire pmod_pkg::sample_frame_t dac_frame,
    output logic                         bick,
    output logic                         lrck,
    output logic                         sdin,
    output logic                         pdn,
    output logic                         sample_strobe,
    output pmod_pkg::sample_frame_t      adc_frame
);
    import pmod_pkg::*;

    logic [6:0]  frame_cnt;
    logic [63:0] adc_shift;
    logic [63:0] adc_shift_next;
    logic [63:0] dac_shift;
    logic        last_bit;

    // Two clocks per bit, 64 bits per frame
    assign bick = frame_cnt[0];
    // High for bit indexes 0 to 31
    assign lrck = ~frame_cnt[6];
    assign sdin = dac_shift[63];

    assign adc_shift_next = {adc_shift[62:0], sdout};

    // Final ADC bit is taken in this cycle
    assign last_bit = (frame_cnt == 7'(frame_clks - 2));

    // Capture on the edge where bick rises
    always_ff @(posedge clk_12mhz) begin
        if (!frame_cnt[0]) begin
            adc_shift <= adc_shift_next;
        end
    end

    always_ff @(posedge clk_12mhz or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt     <= '0;
            pdn           <= 1'b0;
            sample_strobe <= 1'b0;
            adc_frame     <= '0;
            dac_shift     <= '0;
        end else begin
            frame_cnt <= frame_cnt + 7'd1;
            // Codec leaves power-down once we are out of reset
            pdn <= 1'b1;

            // Strobe and frame are valid together at count 127
            sample_strobe <= last_bit;
            if (last_bit) begin
                adc_frame <= sample_frame_t'(adc_shift_next);
            end

            // DAC data moves on bick falling, the load edge is one of them
            if (sample_strobe) begin
                dac_shift <= dac_frame;
            end else if (frame_cnt[0]) begin
                dac_shift <= {dac_shift[62:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/channel_cal.sv
// Input and output calibration for one audio channel.
// Undoes the front-end inversion, applies the ADC gain and offset, then
// the DAC gain and offset, with an optional forced output level.
`timescale 1ns/1ps
`default_nettype none

module channel_cal #(
    parameter pmod_pkg::cal_coef_t adc_coef = '{offset: 16'sd0, gain: 16'sd4096},
    parameter pmod_pkg::cal_coef_t dac_coef = '{offset: 16'sd0, gain: 16'sd4096}
) (
    input  wire logic             clk_12mhz,
    input  wire logic             rst_n,
    input  wire logic             sample_strobe,
    input  wire pmod_pkg::sample_t raw,
    input  wire logic             out_cal,
    input  wire logic             btn_n,
    output pmod_pkg::sample_t     cal_in,
    output pmod_pkg::sample_t     dac_word
);
    import pmod_pkg::*;

    // (x - offset) * gain >> 12, clamped to the sample range
    function automatic sample_t apply_cal(input sample_t x, input cal_coef_t coef);
        logic signed [16:0] diff;
        logic signed [32:0] prod;
        logic signed [20:0] scaled;
        diff   = x - coef.offset;
        prod   = diff * coef.gain;
        scaled = 21'(prod >>> 12);
        if (scaled > 21'sd32767) begin
            return 16'sh7fff;
        end else if (scaled < -21'sd32768) begin
            return 16'sh8000;
        end
        return sample_t'(scaled);
    endfunction

    sample_t in_next;
    sample_t out_next;
    sample_t forced;

    // Analog front end inverts, complement is close enough
    assign in_next  = apply_cal(~raw, adc_coef);
    assign forced   = btn_n ? sample_t'(force_level) : sample_t'(-force_level);
    assign out_next = out_cal ? forced : apply_cal(in_next, dac_coef);

    always_ff @(posedge clk_12mhz or negedge rst_n) begin
        if (!rst_n) begin
            cal_in   <= '0;
            dac_word <= '0;
        end else if (sample_strobe) begin
            cal_in   <= in_next;
            dac_word <= out_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/sample_uart_framer.sv
// Sends one channel's sample per record over the UART.
// A record is "C", "H", the channel digit, then MSB and LSB of the word.
// Channels are visited in turn and the frame LED toggles per record.
`timescale 1ns/1ps
`default_nettype none

module sample_uart_framer (
    input  wire logic                    clk_12mhz,
    input  wire logic                    rst_n,
    input  wire pmod_pkg::sample_frame_t raw_frame,
    input  wire pmod_pkg::sample_frame_t cal_frame,
    input  wire logic                    raw_uart,
    input  wire logic                    uart_busy,
    output logic                         uart_start,
    output logic [7:0]                   uart_data,
    output logic                         led_frame_n
);
    import pmod_pkg::*;

    function automatic sample_t pick(input sample_frame_t f, input logic [1:0] ch);
        case (ch)
            2'd0: pick = f.ch0;
            2'd1: pick = f.ch1;
            2'd2: pick = f.ch2;
            default: pick = f.ch3;
        endcase
    endfunction

    xmit_state_t state;
    logic [1:0]  cur_ch;
    sample_t     word;
    logic        send;

    // Busy only rises a cycle after the start pulse, so skip that cycle
    assign send = !uart_busy && !uart_start;

    always_ff @(posedge clk_12mhz or negedge rst_n) begin
        if (!rst_n) begin
            state       <= xmit_c;
            cur_ch      <= 2'd0;
            uart_start  <= 1'b0;
            led_frame_n <= 1'b1;
        end else begin
            uart_start <= send;
            if (send) begin
                case (state)
                    xmit_c:   state <= xmit_h;
                    xmit_h:   state <= xmit_id;
                    xmit_id:  state <= xmit_msb;
                    xmit_msb: state <= xmit_lsb;
                    xmit_lsb: begin
                        state       <= xmit_c;
                        cur_ch      <= cur_ch + 2'd1;
                        led_frame_n <= ~led_frame_n;
                    end
                    default:  state <= xmit_c;
                endcase
            end
        end
    end

    // Word is held from the first byte so a record never mixes two frames
    always_ff @(posedge clk_12mhz) begin
        if (send) begin
            case (state)
                xmit_c: begin
                    uart_data <= "C";
                    word      <= raw_uart ? pick(raw_frame, cur_ch) : pick(cal_frame, cur_ch);
                end
                xmit_h:   uart_data <= "H";
                xmit_id:  uart_data <= 8'h30 + {6'd0, cur_ch};
                xmit_msb: uart_data <= word[15:8];
                xmit_lsb: uart_data <= word[7:0];
                default:  uart_data <= "C";
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
// 8N1 UART transmitter.
// A one-cycle start pulse loads a byte; busy stays high until the stop bit ends.
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic       clk_12mhz,
    input  wire logic       rst_n,
    input  wire logic       uart_start,
    input  wire logic [7:0] uart_data,
    output logic            tx,
    output logic            uart_busy
);
    import pmod_pkg::*;

    logic [$clog2(clks_per_bit)-1:0] baud_cnt;
    logic [3:0]                      bit_idx;
    logic [9:0]                      shift;

    // Line idles high since the shift register refills with ones
    assign tx = shift[0];

    always_ff @(posedge clk_12mhz or negedge rst_n) begin
        if (!rst_n) begin
            shift     <= '1;
            uart_busy <= 1'b0;
            baud_cnt  <= '0;
            bit_idx   <= '0;
        end else if (!uart_busy) begin
            if (uart_start) begin
                // Stop bit, data LSB first, start bit
                shift     <= {1'b1, uart_data, 1'b0};
                uart_busy <= 1'b1;
                baud_cnt  <= '0;
                bit_idx   <= '0;
            end
        end else if (baud_cnt == ($bits(baud_cnt))'(clks_per_bit - 1)) begin
            baud_cnt <= '0;
            shift    <= {1'b1, shift[9:1]};
            if (bit_idx == 4'd9) begin
                uart_busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/pmod_top.sv
// Top level of the eurorack codec interface.
// Input samples are calibrated and mirrored back to the outputs, and
// the calibrated or raw samples are streamed out over the UART.
`timescale 1ns/1ps
`default_nettype none

module pmod_top (
    input  wire logic clk_12mhz,
    input  wire logic rst_n,
    input  wire logic sdout,
    input  wire logic out_cal,
    input  wire logic btn_n,
    input  wire logic raw_uart,
    output logic      bick,
    output logic      lrck,
    output logic      sdin,
    output logic      pdn,
    output logic      tx,
    output logic      led_frame_n
);
    import pmod_pkg::*;

    sample_frame_t adc_frame;
    sample_frame_t cal_frame;
    sample_frame_t dac_frame;
    logic          sample_strobe;
    logic          uart_start;
    logic [7:0]    uart_data;
    logic          uart_busy;

    // Index 0 is the leftmost element, which lines up with ch0
    sample_t [0:n_channels-1] adc_words;
    sample_t [0:n_channels-1] cal_words;
    sample_t [0:n_channels-1] dac_words;

    assign adc_words = adc_frame;
    assign cal_frame = cal_words;
    assign dac_frame = dac_words;

    codec_serial codec_i (
        .clk_12mhz     (clk_12mhz),
        .rst_n         (rst_n),
        .sdout         (sdout),
        .dac_frame     (dac_frame),
        .bick          (bick),
        .lrck          (lrck),
        .sdin          (sdin),
        .pdn           (pdn),
        .sample_strobe (sample_strobe),
        .adc_frame     (adc_frame)
    );

    for (genvar i = 0; i < n_channels; i++) begin : g_cal
        channel_cal #(
            .adc_coef (adc_cal_tab[i]),
            .dac_coef (dac_cal_tab[i])
        ) cal_i (
            .clk_12mhz     (clk_12mhz),
            .rst_n         (rst_n),
            .sample_strobe (sample_strobe),
            .raw           (adc_words[i]),
            .out_cal       (out_cal),
            .btn_n         (btn_n),
            .cal_in        (cal_words[i]),
            .dac_word      (dac_words[i])
        );
    end

    sample_uart_framer framer_i (
        .clk_12mhz   (clk_12mhz),
        .rst_n       (rst_n),
        .raw_frame   (adc_frame),
        .cal_frame   (cal_frame),
        .raw_uart    (raw_uart),
        .uart_busy   (uart_busy),
        .uart_start  (uart_start),
        .uart_data   (uart_data),
        .led_frame_n (led_frame_n)
    );

    uart_tx uart_i (
        .clk_12mhz  (clk_12mhz),
        .rst_n      (rst_n),
        .uart_start (uart_start),
        .uart_data  (uart_data),
        .tx         (tx),
        .uart_busy  (uart_busy)
    );

endmodule

`default_nettype wire

// File: bench/tb_pmod_top.sv
// Testbench for the eurorack codec interface top level.
// A codec model feeds ADC frames, while the DAC stream and the UART records
// are decoded and compared with calibration values worked out here.
`timescale 1ns/1ps
`default_nettype none

module tb_pmod_top;
    import pmod_pkg::*;

    // Six tests of up to about 40 frames of 128 clocks, UART records included
    localparam int timeout_cycles = 40000;

    logic clk_12mhz = 1'b0;
    logic rst_n, out_cal, btn_n, raw_uart;
    logic sdout = 1'b0;
    logic bick, lrck, sdin, pdn, tx, led_frame_n;

    sample_frame_t adc_codes = '0;
    sample_frame_t dac_rx = '0;
    logic [63:0]   dac_bits = '0;
    logic [6:0]    slot_cnt = '0;
    logic          led_last = 1'b1;
    logic          lrck_last = 1'b0;
    int            dac_frames = 0;
    int            led_toggles = 0;
    int            cycles = 0;
    int            errors = 0;
    int            rnd_seed;
    string         cur_test = "init";

    pmod_top dut_i (
        .clk_12mhz   (clk_12mhz),
        .rst_n       (rst_n),
        .sdout       (sdout),
        .out_cal     (out_cal),
        .btn_n       (btn_n),
        .raw_uart    (raw_uart),
        .bick        (bick),
        .lrck        (lrck),
        .sdin        (sdin),
        .pdn         (pdn),
        .tx          (tx),
        .led_frame_n (led_frame_n)
    );

    always #50 clk_12mhz = ~clk_12mhz;

    // Position in the codec frame, the DAC reader takes sdin where bick rises
    always @(posedge clk_12mhz) begin
        if (!rst_n) begin
            slot_cnt   <= '0;
            dac_frames <= 0;
        end else begin
            // Bit and frame clocks follow the frame position
            check_level("bick", slot_cnt[0], bick);
            check_level("lrck", ~slot_cnt[6], lrck);
            slot_cnt <= slot_cnt + 7'd1;
            if (slot_cnt[0]) begin
                dac_bits <= {dac_bits[62:0], sdin};
                if (slot_cnt == 7'd127) begin
                    dac_rx     <= {dac_bits[62:0], sdin};
                    dac_frames <= dac_frames + 1;
                end
            end
        end
    end

    // Codec model, next ADC bit goes out one clock before bick rises
    always @(posedge clk_12mhz) begin : codec_model
        int k;
        k = ((int'(slot_cnt) + 1) / 2) % 64;
        if (rst_n && slot_cnt[0]) begin
            sdout <= adc_codes[63 - k];
        end
    end

    always @(posedge clk_12mhz) begin
        if (rst_n && dac_frames != 0 && slot_cnt == 7'd0
                && !(lrck === 1'b1 && lrck_last === 1'b0)) begin
            errors = errors + 1;
            $display("%s: lrck did not rise at the start of frame %0d", cur_test, dac_frames);
        end
        lrck_last <= lrck;
        if (!rst_n) begin
            led_toggles <= 0;
        end else if (led_frame_n !== led_last) begin
            led_toggles <= led_toggles + 1;
        end
        led_last <= led_frame_n;
    end

    always @(posedge clk_12mhz) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Run stopped after %0d cycles, %s never finished", cycles, cur_test);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_sample(input string what, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERR %s %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERR %s %s expected 0x%02h actual 0x%02h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_level(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERR %s %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    function automatic sample_t slot(input sample_frame_t f, input int ch);
        logic [63:0] v;
        v = f;
        return sample_t'(v[63 - 16*ch -: 16]);
    endfunction

    function automatic sample_frame_t rand_frame();
        return sample_frame_t'({$urandom(), $urandom()});
    endfunction

    // Offset and Q4.12 gain, floor shift by 12, clamp to 16 bits
    function automatic sample_t gain_step(input longint x, input cal_coef_t coef);
        longint v;
        v = ((x - longint'(coef.offset)) * longint'(coef.gain)) >>> 12;
        if (v > 32767) begin
            v = 32767;
        end else if (v < -32768) begin
            v = -32768;
        end
        return sample_t'(v);
    endfunction

    // Front end inverts, the complement of a code is -code - 1
    function automatic sample_t exp_cal_in(input sample_t code, input int ch);
        return gain_step(-longint'(code) - 1, adc_cal_tab[ch]);
    endfunction

    function automatic sample_t exp_dac(input sample_t code, input int ch);
        return gain_step(longint'(exp_cal_in(code, ch)), dac_cal_tab[ch]);
    endfunction

    function automatic string byte_label(input xmit_state_t st);
        case (st)
            xmit_c:   return "byte C";
            xmit_h:   return "byte H";
            xmit_id:  return "channel digit";
            xmit_msb: return "MSB";
            default:  return "LSB";
        endcase
    endfunction

    // New codes are in place before bit 0 of the next frame is driven
    task automatic apply_codes(input sample_frame_t f);
        @(posedge clk_12mhz);
        while (slot_cnt != 7'd126) @(posedge clk_12mhz);
        adc_codes <= f;
    endtask

    task automatic wait_dac_frames(input int n);
        int target;
        target = dac_frames + n;
        while (dac_frames != target) @(posedge clk_12mhz);
    endtask

    task automatic recv_byte(output logic [7:0] b);
        int idle;
        b = 8'h00;
        idle = 0;
        @(posedge clk_12mhz);
        while (tx !== 1'b0 && idle < 400) begin
            @(posedge clk_12mhz);
            idle = idle + 1;
        end
        if (tx !== 1'b0) begin
            errors = errors + 1;
            $display("%s: no UART start bit within %0d clocks", cur_test, idle);
        end else begin
            repeat (clks_per_bit / 2 - 1) @(posedge clk_12mhz);
            if (tx !== 1'b0) begin
                errors = errors + 1;
                $display("%s: UART start bit ended before mid-bit", cur_test);
            end
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(posedge clk_12mhz);
                b[i] = tx;
            end
            repeat (clks_per_bit) @(posedge clk_12mhz);
            check_level("stop bit", 1'b1, tx);
        end
    endtask

    task automatic verify_dac(input sample_frame_t codes, input logic forced);
        sample_t exp;
        for (int c = 0; c < n_channels; c++) begin
            if (forced) begin
                exp = btn_n ? sample_t'(force_level) : sample_t'(-force_level);
            end else begin
                exp = exp_dac(slot(codes, c), c);
            end
            check_sample($sformatf("dac ch%0d", c), exp, slot(dac_rx, c));
        end
    endtask

    task automatic run_records(input logic raw, input sample_frame_t codes);
        int          toggles_start;
        int          ch;
        logic [7:0]  b;
        logic [7:0]  exp_b;
        sample_t     word;
        xmit_state_t st;
        @(posedge clk_12mhz);
        raw_uart <= raw;
        apply_codes(codes);
        wait_dac_frames(3);
        // Resync on the LSB of the record in flight
        toggles_start = led_toggles;
        while (led_toggles == toggles_start) @(posedge clk_12mhz);
        toggles_start = led_toggles;
        ch = toggles_start % n_channels;
        recv_byte(b);
        for (int r = 0; r < 8; r++) begin
            word = raw ? slot(codes, ch) : exp_cal_in(slot(codes, ch), ch);
            for (int i = 0; i < 5; i++) begin
                st = xmit_state_t'(i);
                case (st)
                    xmit_c:   exp_b = "C";
                    xmit_h:   exp_b = "H";
                    xmit_id:  exp_b = 8'h30 + 8'(ch);
                    xmit_msb: exp_b = word[15:8];
                    default:  exp_b = word[7:0];
                endcase
                recv_byte(b);
                check_byte(byte_label(st), exp_b, b);
            end
            if (led_toggles != toggles_start + r + 1) begin
                errors = errors + 1;
                $display("%s: led_frame_n toggled %0d times in %0d records", cur_test,
                         led_toggles - toggles_start, r + 1);
            end
            ch = (ch + 1) % n_channels;
        end
    endtask

    task automatic test_reset();
        cur_test = "test_reset";
        repeat (2) @(posedge clk_12mhz);
        rst_n <= 1'b1;
        @(posedge clk_12mhz);
        check_level("tx", 1'b1, tx);
        check_level("pdn", 1'b0, pdn);
        check_level("led_frame_n", 1'b1, led_frame_n);
        check_level("sdin", 1'b0, sdin);
        @(posedge clk_12mhz);
        check_level("pdn released", 1'b1, pdn);
    endtask

    task automatic test_loopback();
        sample_frame_t codes;
        cur_test = "test_loopback";
        for (int n = 0; n < 8; n++) begin
            codes = rand_frame();
            apply_codes(codes);
            wait_dac_frames(4);
            verify_dac(codes, 1'b0);
        end
    endtask

    task automatic test_saturation();
        sample_frame_t codes;
        cur_test = "test_saturation";
        for (int k = 0; k < 2; k++) begin
            codes = (k == 0) ? {4{16'h8000}} : {4{16'h7fff}};
            apply_codes(codes);
            wait_dac_frames(4);
            verify_dac(codes, 1'b0);
        end
    endtask

    task automatic test_output_cal();
        cur_test = "test_output_cal";
        for (int k = 0; k < 2; k++) begin
            @(posedge clk_12mhz);
            out_cal <= 1'b1;
            btn_n   <= (k == 0);
            apply_codes(rand_frame());
            wait_dac_frames(4);
            verify_dac(adc_codes, 1'b1);
        end
        @(posedge clk_12mhz);
        out_cal <= 1'b0;
        btn_n   <= 1'b1;
    endtask

    task automatic test_uart_records();
        cur_test = "test_uart_records";
        run_records(1'b0, rand_frame());
    endtask

    task automatic test_uart_raw();
        cur_test = "test_uart_raw";
        run_records(1'b1, rand_frame());
    endtask

    initial begin
        rnd_seed = $urandom(32'h8647);
        rst_n    = 1'b0;
        out_cal  = 1'b0;
        btn_n    = 1'b1;
        raw_uart = 1'b0;
        test_reset();
        test_loopback();
        test_saturation();
        test_output_cal();
        test_uart_records();
        test_uart_raw();
        $display("Run complete after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hw/pmod_pkg.sv
hw/codec_serial.sv
hw/channel_cal.sv
hw/sample_uart_framer.sv
hw/uart_tx.sv
hw/pmod_top.sv
bench/tb_pmod_top.sv
